//--- src/cnn_macros.svh
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// input image geometry
`define IMG_W 28
`define IMG_H 28

// square kernel, no padding
`define K_SIZE 3

// datapath widths
`define PIX_W 8
`define WGT_W 4
`define BIAS_W 12
`define ACC_W 18
`define SHIFT_W 3

// credit depths on both streams
`define IN_CREDITS 4
`define OUT_CREDITS 4

// pooled row length and outputs per frame
`define POOL_W 13
`define FRAME_OUTS (`POOL_W * `POOL_W)

// configuration port
`define CFG_ADDR_W 4
`define CFG_DATA_W 16
`define FRAME_CNT_W 16

`endif

//--- src/cnn_pkg.sv
`include "cnn_macros.svh"

package cnn_pkg;

	// configuration register map
	typedef enum logic [`CFG_ADDR_W-1:0] {
		CFG_W0,
		CFG_W1,
		CFG_W2,
		CFG_W3,
		CFG_W4,
		CFG_W5,
		CFG_W6,
		CFG_W7,
		CFG_W8,
		CFG_BIAS,
		CFG_SHIFT,
		CFG_FRAMES
	} cfg_reg_e;

	// window builder fill state
	typedef enum logic {
		WIN_FILL,
		WIN_RUN
	} win_state_e;

	// weights are row-major, index 0 is top-left
	typedef struct packed {
		logic [`K_SIZE*`K_SIZE-1:0][`WGT_W-1:0] wgt;
		logic [`BIAS_W-1:0]                     bias;
		logic [`SHIFT_W-1:0]                    shift;
	} cfg_bus_t;

	typedef struct packed {
		logic [`K_SIZE*`K_SIZE-1:0][`PIX_W-1:0] pix;
		logic                                   valid;
	} window_t;

	typedef struct packed {
		logic [`PIX_W-1:0] pixel;
		logic              valid;
		logic              eor;
	} conv_out_t;

endpackage

//--- src/cnn_cfg_regs.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_cfg_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cfg_we,
	input  cnn_pkg::cfg_reg_e      cfg_addr,
	input  logic [`CFG_DATA_W-1:0] cfg_wdata,
	output logic [`CFG_DATA_W-1:0] cfg_rdata,
	input  logic                   frame_done,
	output cnn_pkg::cfg_bus_t      cfg
);

	import cnn_pkg::*;

	logic [`FRAME_CNT_W-1:0] frame_cnt;
	logic                    wgt_sel;

	// addresses 0 to 8 select a weight slot
	assign wgt_sel = (cfg_addr <= CFG_W8);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (cfg_we) begin
			if (wgt_sel) begin
				cfg.wgt[cfg_addr] <= cfg_wdata[`WGT_W-1:0];
			end
			if (cfg_addr == CFG_BIAS) begin
				cfg.bias <= cfg_wdata[`BIAS_W-1:0];
			end
			if (cfg_addr == CFG_SHIFT) begin
				cfg.shift <= cfg_wdata[`SHIFT_W-1:0];
			end
		end
	end

	// frame count is read only, bumped by the pool stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (frame_done) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// combinational read-back, signed fields are sign extended
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			CFG_BIAS: begin
				cfg_rdata = {{(`CFG_DATA_W-`BIAS_W){cfg.bias[`BIAS_W-1]}}, cfg.bias};
			end
			CFG_SHIFT: begin
				cfg_rdata = {{(`CFG_DATA_W-`SHIFT_W){1'b0}}, cfg.shift};
			end
			CFG_FRAMES: begin
				cfg_rdata = frame_cnt;
			end
			default: begin
				if (wgt_sel) begin
					cfg_rdata = {{(`CFG_DATA_W-`WGT_W){cfg.wgt[cfg_addr][`WGT_W-1]}},
						cfg.wgt[cfg_addr]};
				end
			end
		endcase
	end

endmodule

//--- src/window_builder.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module window_builder (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic [`PIX_W-1:0] in_pixel,
	output logic              in_credit,
	input  logic              stall,
	output cnn_pkg::window_t  win
);

	import cnn_pkg::*;

	localparam int K     = `K_SIZE;
	localparam int PTR_W = $clog2(`IN_CREDITS);
	localparam int CW    = $clog2(`IMG_W);
	localparam int RW    = $clog2(`IMG_H);

	// input buffer, depth is a power of two so pointers wrap naturally
	logic [`PIX_W-1:0] fifo_mem [`IN_CREDITS];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    fifo_cnt;
	logic              pop;

	// line_a holds the previous row, line_b the one before it
	logic [`PIX_W-1:0] line_a [`IMG_W];
	logic [`PIX_W-1:0] line_b [`IMG_W];
	logic [`PIX_W-1:0] new_col [K];

	logic [CW-1:0]     col;
	logic [RW-1:0]     row;
	logic              last_pix;
	logic              fill_done;
	win_state_e        state_q;

	logic [K*K-1:0][`PIX_W-1:0] win_pix;
	logic                       win_valid;

	assign pop       = (fifo_cnt != '0) && !stall;
	assign last_pix  = (col == CW'(`IMG_W-1)) && (row == RW'(`IMG_H-1));
	assign fill_done = (col == CW'(K-1)) && (row == RW'(K-1));

	always_ff @(posedge clk) begin
		if (in_valid) begin
			fifo_mem[wr_ptr] <= in_pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fifo_cnt  <= '0;
			in_credit <= 1'b0;
		end else begin
			wr_ptr    <= wr_ptr + PTR_W'(in_valid);
			rd_ptr    <= rd_ptr + PTR_W'(pop);
			fifo_cnt  <= fifo_cnt + in_valid - pop;
			// one credit back per pixel moved into the line buffers
			in_credit <= pop;
		end
	end

	// column entering the window, oldest row on top
	always_comb begin
		new_col[0] = line_b[col];
		new_col[1] = line_a[col];
		new_col[2] = fifo_mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			line_b[col] <= line_a[col];
			line_a[col] <= fifo_mem[rd_ptr];
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K-1; c++) begin
					win_pix[r*K+c] <= win_pix[r*K+c+1];
				end
				win_pix[r*K+K-1] <= new_col[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col       <= '0;
			row       <= '0;
			state_q   <= WIN_FILL;
			win_valid <= 1'b0;
		end else if (!stall) begin
			win_valid <= pop && (col >= CW'(K-1)) && (state_q == WIN_RUN || fill_done);
			if (pop) begin
				col <= (col == CW'(`IMG_W-1)) ? '0 : col + 1'b1;
				if (col == CW'(`IMG_W-1)) begin
					row <= (row == RW'(`IMG_H-1)) ? '0 : row + 1'b1;
				end
				// back to fill at the frame wrap
				if (last_pix) begin
					state_q <= WIN_FILL;
				end else if (state_q == WIN_FILL && fill_done) begin
					state_q <= WIN_RUN;
				end
			end
		end
	end

	assign win = '{pix: win_pix, valid: win_valid};

endmodule

//--- src/conv_relu.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module conv_relu (
	input  logic               clk,
	input  logic               rst_n,
	input  cnn_pkg::window_t   win,
	input  cnn_pkg::cfg_bus_t  cfg,
	input  logic               stall,
	output cnn_pkg::conv_out_t res
);

	localparam int N      = `K_SIZE * `K_SIZE;
	localparam int PROD_W = `WGT_W + `PIX_W + 1;
	localparam int OUT_W  = `IMG_W - `K_SIZE + 1;
	localparam int COL_W  = $clog2(OUT_W);
	localparam logic signed [`ACC_W-1:0] PIX_MAX = (1 << `PIX_W) - 1;

	// stage one products
	logic signed [PROD_W-1:0] prod_q [N];
	logic                     v1_q;

	// stage two
	logic signed [`ACC_W-1:0] acc;
	logic signed [`ACC_W-1:0] shifted;
	logic [`PIX_W-1:0]        sat;
	logic [COL_W-1:0]         res_col;
	logic [`PIX_W-1:0]        res_pixel;
	logic                     res_valid;
	logic                     res_eor;

	// pixels are unsigned, so widen with a zero before the signed multiply
	always_ff @(posedge clk) begin
		if (!stall) begin
			for (int i = 0; i < N; i++) begin
				prod_q[i] <= $signed(cfg.wgt[i]) * $signed({1'b0, win.pix[i]});
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1_q <= 1'b0;
		end else if (!stall) begin
			v1_q <= win.valid;
		end
	end

	// adder tree plus bias, then relu, shift and clamp
	always_comb begin
		acc = `ACC_W'($signed(cfg.bias));
		for (int i = 0; i < N; i++) begin
			acc = acc + `ACC_W'(prod_q[i]);
		end
		shifted = acc >>> cfg.shift;
		if (acc < 0) begin
			sat = '0;
		end else if (shifted > PIX_MAX) begin
			sat = '1;
		end else begin
			sat = shifted[`PIX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && v1_q) begin
			res_pixel <= sat;
		end
	end

	// end of row on the 26th result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			res_eor   <= 1'b0;
			res_col   <= '0;
		end else if (!stall) begin
			res_valid <= v1_q;
			res_eor   <= v1_q && (res_col == COL_W'(OUT_W-1));
			if (v1_q) begin
				res_col <= (res_col == COL_W'(OUT_W-1)) ? '0 : res_col + 1'b1;
			end
		end
	end

	assign res = '{pixel: res_pixel, valid: res_valid, eor: res_eor};

endmodule

//--- src/max_pool.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module max_pool (
	input  logic               clk,
	input  logic               rst_n,
	input  cnn_pkg::conv_out_t res,
	input  logic               out_credit,
	output logic               out_valid,
	output logic [`PIX_W-1:0]  out_pixel,
	output logic               stall,
	output logic               frame_done
);

	localparam int CW    = $clog2(`IMG_W);
	localparam int CRD_W = $clog2(`OUT_CREDITS + 1) + 1;
	localparam int OCW   = $clog2(`FRAME_OUTS);

	// pair maxima from the even row
	logic [`PIX_W-1:0] half_buf [`POOL_W];
	logic [`PIX_W-1:0] held;
	logic [CW-1:0]     col;
	logic              row_odd;
	logic [CRD_W-1:0]  credits;
	logic [OCW-1:0]    out_cnt;
	logic              emit_slot;
	logic              take;
	logic              issue;

	function automatic logic [`PIX_W-1:0] max8(input logic [`PIX_W-1:0] a,
		input logic [`PIX_W-1:0] b);
		return (a > b) ? a : b;
	endfunction

	// second pixel of a pair on an odd row completes a 2 by 2 block
	assign emit_slot = row_odd && col[0];
	assign stall     = res.valid && emit_slot && (credits == '0);
	assign take      = res.valid && !stall;
	assign issue     = take && emit_slot;

	always_ff @(posedge clk) begin
		if (take && !col[0]) begin
			held <= res.pixel;
		end
		if (take && col[0] && !row_odd) begin
			half_buf[col[CW-1:1]] <= max8(held, res.pixel);
		end
		if (issue) begin
			out_pixel <= max8(max8(held, res.pixel), half_buf[col[CW-1:1]]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col        <= '0;
			row_odd    <= 1'b0;
			credits    <= CRD_W'(`OUT_CREDITS);
			out_cnt    <= '0;
			out_valid  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			out_valid  <= issue;
			frame_done <= issue && (out_cnt == OCW'(`FRAME_OUTS-1));
			credits    <= credits + out_credit - issue;
			if (take) begin
				col <= res.eor ? '0 : col + 1'b1;
				if (res.eor) begin
					row_odd <= !row_odd;
				end
			end
			if (issue) begin
				out_cnt <= (out_cnt == OCW'(`FRAME_OUTS-1)) ? '0 : out_cnt + 1'b1;
			end
		end
	end

endmodule

//--- src/cnn_layer_top.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_layer_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic [`PIX_W-1:0]      in_pixel,
	output logic                   in_credit,
	output logic                   out_valid,
	output logic [`PIX_W-1:0]      out_pixel,
	input  logic                   out_credit,
	input  logic                   cfg_we,
	input  cnn_pkg::cfg_reg_e      cfg_addr,
	input  logic [`CFG_DATA_W-1:0] cfg_wdata,
	output logic [`CFG_DATA_W-1:0] cfg_rdata
);

	import cnn_pkg::*;

	cfg_bus_t  cfg_bus;
	window_t   win;
	conv_out_t conv_res;
	// pool back-pressure holds every stage
	logic      stall;
	logic      frame_done;

	cnn_cfg_regs cnn_cfg_regs_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.frame_done (frame_done),
		.cfg        (cfg_bus)
	);

	window_builder window_builder_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_pixel  (in_pixel),
		.in_credit (in_credit),
		.stall     (stall),
		.win       (win)
	);

	conv_relu conv_relu_i (
		.clk   (clk),
		.rst_n (rst_n),
		.win   (win),
		.cfg   (cfg_bus),
		.stall (stall),
		.res   (conv_res)
	);

	max_pool max_pool_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.res        (conv_res),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel),
		.stall      (stall),
		.frame_done (frame_done)
	);

endmodule

//--- sim/cnn_props.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_props (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_credit,
	input logic out_valid,
	input logic out_credit,
	input logic frame_done
);

	// outstanding input pixels and credits left at the pool stage
	int in_outstanding;
	int out_avail;
	int prop_errors = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_outstanding <= 0;
			out_avail      <= `OUT_CREDITS;
		end else begin
			in_outstanding <= in_outstanding + int'(in_valid) - int'(in_credit);
			out_avail      <= out_avail + int'(out_credit) - int'(out_valid);
		end
	end

	in_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> in_outstanding < `IN_CREDITS)
		else begin
			$error("pixel sent with no input credit left");
			prop_errors++;
		end

	credit_has_pixel: assert property (@(posedge clk) disable iff (!rst_n)
		in_credit |-> in_outstanding > 0)
		else begin
			$error("input credit returned with no pixel outstanding");
			prop_errors++;
		end

	out_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_avail > 0)
		else begin
			$error("output sent with no output credit");
			prop_errors++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !out_valid && !in_credit && !frame_done)
		else begin
			$error("outputs active right after reset");
			prop_errors++;
		end

endmodule

bind cnn_layer_top cnn_props cnn_props_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_credit  (in_credit),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.frame_done (frame_done)
);

//--- sim/tb_cnn.sv
`timescale 1ns/1ps
`include "cnn_macros.svh"

module tb_cnn;

	import cnn_pkg::*;

	localparam int NPIX     = `IMG_W * `IMG_H;
	localparam int CONV_W   = `IMG_W - `K_SIZE + 1;
	localparam int CLK_NS   = 4;
	// five frames of pixels, times four for stalls
	localparam int WDOG_CYC = 5 * NPIX * 4;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   in_valid;
	logic [`PIX_W-1:0]      in_pixel;
	logic                   in_credit;
	logic                   out_valid;
	logic [`PIX_W-1:0]      out_pixel;
	logic                   out_credit;
	logic                   cfg_we;
	cfg_reg_e               cfg_addr;
	logic [`CFG_DATA_W-1:0] cfg_wdata;
	logic [`CFG_DATA_W-1:0] cfg_rdata;

	// stimulus and reference model state
	logic [`PIX_W-1:0] img [NPIX];
	int                wgt [9];
	int                bias;
	int                shift;
	logic [`PIX_W-1:0] exp_q [$];
	int                const_val = -1;
	bit                in_gaps = 1'b0;
	bit                hold_credits = 1'b0;

	int sent = 0;
	int credits_back = 0;
	int recv_cnt = 0;
	int returned = 0;
	int pos = 0;
	int done_cnt = 0;
	int mon_errors = 0;
	int chk_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int e0;

	cnn_layer_top cnn_layer_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_pixel   (in_pixel),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel),
		.out_credit (out_credit),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic int error_total();
		return mon_errors + chk_errors + cnn_layer_top_i.cnn_props_i.prop_errors;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			credits_back = 0;
		end else if (in_credit) begin
			credits_back++;
		end
	end

	// outputs compared in order with the model queue
	always @(posedge clk) begin
		logic [`PIX_W-1:0] want;
		if (!rst_n) begin
			recv_cnt = 0;
			pos = 0;
			done_cnt = 0;
		end else begin
			check_done: assert (cnn_layer_top_i.frame_done ==
				(out_valid && pos == `FRAME_OUTS - 1)) else begin
				$display("[ERROR] %0t frame_done out of step at output %0d", $time, pos);
				mon_errors++;
			end
			if (cnn_layer_top_i.frame_done) begin
				done_cnt++;
			end
			if (out_valid) begin
				recv_cnt++;
				pos = (pos == `FRAME_OUTS - 1) ? 0 : pos + 1;
				if (exp_q.size() == 0) begin
					$display("an output arrived at %0t when none was expected", $time);
					mon_errors++;
				end else begin
					want = exp_q.pop_front();
					check_pixel: assert (out_pixel == want) else begin
						$display("[ERROR] %0t output %0d: got %0d, expected %0d",
							$time, recv_cnt, out_pixel, want);
						mon_errors++;
					end
					if (const_val >= 0) begin
						check_const: assert (int'(out_pixel) == const_val) else begin
							$display("[ERROR] %0t output %0d is %0d, not %0d",
								$time, recv_cnt, out_pixel, const_val);
							mon_errors++;
						end
					end
				end
			end
		end
	end

	// receiver returns one credit per output after optional hold-offs
	initial begin : credit_driver
		int hold_left;
		hold_left = 0;
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (!rst_n) begin
				returned = 0;
				hold_left = 0;
				out_credit = 1'b0;
			end else begin
				if (hold_credits && hold_left == 0 && $urandom_range(7, 0) == 0) begin
					hold_left = int'($urandom_range(40, 5));
				end
				if (hold_left > 0) begin
					hold_left--;
					out_credit = 1'b0;
				end else if (recv_cnt > returned) begin
					out_credit = 1'b1;
					returned++;
				end else begin
					out_credit = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WDOG_CYC * CLK_NS);
		$display("watchdog: run did not finish within %0d cycles", WDOG_CYC);
		$display("Verification failed");
		$finish;
	end

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		sent = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic cfg_write(input cfg_reg_e addr, input logic [`CFG_DATA_W-1:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	task automatic cfg_expect(input cfg_reg_e addr, input logic [`CFG_DATA_W-1:0] want);
		cfg_addr = addr;
		#1;
		check_cfg: assert (cfg_rdata == want) else begin
			$display("[ERROR] %0t read of %s: got %h, expected %h",
				$time, addr.name(), cfg_rdata, want);
			chk_errors++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic pick_weights(input int lo, input int hi);
		for (int i = 0; i < 9; i++) begin
			wgt[i] = lo + int'($urandom_range(hi - lo, 0));
		end
	endtask

	task automatic program_cfg();
		for (int i = 0; i < 9; i++) begin
			cfg_write(cfg_reg_e'(i), `CFG_DATA_W'(wgt[i]));
		end
		cfg_write(CFG_BIAS, `CFG_DATA_W'(bias));
		cfg_write(CFG_SHIFT, `CFG_DATA_W'(shift));
	endtask

	task automatic random_image();
		for (int p = 0; p < NPIX; p++) begin
			img[p] = `PIX_W'($urandom_range(255, 0));
		end
	endtask

	// valid conv with relu, shift and clamp, then 2x2 max in row-major order
	task automatic expect_frame();
		int conv [CONV_W][CONV_W];
		int acc;
		int v;
		int m;
		for (int r = 0; r < CONV_W; r++) begin
			for (int c = 0; c < CONV_W; c++) begin
				acc = bias;
				for (int i = 0; i < 9; i++) begin
					acc += wgt[i] * int'(img[(r + i / 3) * `IMG_W + c + i % 3]);
				end
				v = (acc < 0) ? 0 : acc >>> shift;
				conv[r][c] = (v > 255) ? 255 : v;
			end
		end
		for (int pr = 0; pr < `POOL_W; pr++) begin
			for (int pc = 0; pc < `POOL_W; pc++) begin
				m = 0;
				for (int k = 0; k < 4; k++) begin
					v = conv[2 * pr + k / 2][2 * pc + k % 2];
					m = (v > m) ? v : m;
				end
				exp_q.push_back(`PIX_W'(m));
			end
		end
	endtask

	task automatic send_frame();
		for (int p = 0; p < NPIX; p++) begin
			while (sent - credits_back >= `IN_CREDITS ||
				(in_gaps && $urandom_range(3, 0) == 0)) begin
				in_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_valid = 1'b1;
			in_pixel = img[p];
			sent++;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || recv_cnt != returned) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_frame();
		random_image();
		expect_frame();
		send_frame();
		wait_drain();
	endtask

	task automatic finish_test(input string name);
		int now_err;
		now_err = error_total();
		tests_run++;
		if (now_err == e0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, now_err - e0);
		end
	endtask

	initial begin
		void'($urandom(87));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_pixel = '0;
		cfg_we = 1'b0;
		cfg_addr = CFG_W0;
		cfg_wdata = '0;
		apply_reset();

		e0 = error_total();
		pick_weights(-8, 7);
		bias = int'($urandom_range(4095, 0)) - 2048;
		shift = int'($urandom_range(7, 0));
		program_cfg();
		for (int i = 0; i < 9; i++) begin
			cfg_expect(cfg_reg_e'(i), `CFG_DATA_W'(wgt[i]));
		end
		cfg_expect(CFG_BIAS, `CFG_DATA_W'(bias));
		cfg_expect(CFG_SHIFT, `CFG_DATA_W'(shift));
		cfg_write(CFG_FRAMES, 16'h00a5);
		cfg_expect(CFG_FRAMES, '0);
		finish_test("config read-back");

		e0 = error_total();
		pick_weights(-8, 7);
		bias = int'($urandom_range(1023, 0)) - 512;
		shift = int'($urandom_range(5, 2));
		program_cfg();
		run_frame();
		finish_test("random frame");

		// non-positive products and the lowest bias
		e0 = error_total();
		pick_weights(-8, 0);
		bias = -2048;
		const_val = 0;
		program_cfg();
		run_frame();
		pick_weights(0, 7);
		bias = 2047;
		shift = 0;
		const_val = 255;
		program_cfg();
		run_frame();
		const_val = -1;
		finish_test("relu and saturation");

		e0 = error_total();
		pick_weights(-8, 7);
		bias = int'($urandom_range(1023, 0)) - 512;
		shift = 3;
		program_cfg();
		hold_credits = 1'b1;
		in_gaps = 1'b1;
		run_frame();
		hold_credits = 1'b0;
		in_gaps = 1'b0;
		finish_test("output credit stalls");

		e0 = error_total();
		check_in_credits: assert (credits_back == sent) else begin
			$display("[ERROR] %0t %0d input credits back for %0d pixels",
				$time, credits_back, sent);
			chk_errors++;
		end
		finish_test("input credits");

		e0 = error_total();
		apply_reset();
		pick_weights(-8, 7);
		shift = 2;
		program_cfg();
		random_image();
		expect_frame();
		send_frame();
		random_image();
		expect_frame();
		send_frame();
		wait_drain();
		check_done_cnt: assert (done_cnt == 2) else begin
			$display("[ERROR] %0t frame_done pulsed %0d times", $time, done_cnt);
			chk_errors++;
		end
		cfg_expect(CFG_FRAMES, `CFG_DATA_W'(2));
		finish_test("frame count");

		$display("tests %0d, failed %0d, errors %0d",
			tests_run, tests_failed, error_total());
		if (tests_failed == 0 && error_total() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+src
src/cnn_pkg.sv
src/cnn_cfg_regs.sv
src/window_builder.sv
src/conv_relu.sv
src/max_pool.sv
src/cnn_layer_top.sv
sim/cnn_props.sv
sim/tb_cnn.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cnn
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
